// ==== verilog/mfu_types_pkg.sv ====
package mfu_types_pkg;

    // Vector geometry
    localparam int NUM_LANES  = 2;
    localparam int LANE_WIDTH = 8;

    // Register-file geometry, one entry holds a full vector
    localparam int VRF_DEPTH  = 16;
    localparam int VRF_AWIDTH = 4;

    typedef logic signed [LANE_WIDTH-1:0] lane_t;
    typedef lane_t [NUM_LANES-1:0] mfu_vector_t;
    typedef logic [VRF_AWIDTH-1:0] vrf_addr_t;

    // Operation select, encoding matches the external opcode field
    typedef enum logic [1:0] {
        ACTIVATION = 2'd0,
        ELT_ADD    = 2'd1,
        ELT_MUL    = 2'd2,
        BYPASS     = 2'd3
    } mfu_op_e;

    typedef enum logic {
        ACT_RELU = 1'b0,
        ACT_TANH = 1'b1
    } act_type_e;

    // Destination bank of a register-file write
    typedef enum logic {
        BANK_ADD = 1'b0,
        BANK_MUL = 1'b1
    } vrf_bank_e;

    // Cycles from the in_valid edge to the out_valid edge
    localparam int ELT_LATENCY    = 2;
    localparam int RELU_LATENCY   = 2;
    localparam int TANH_LATENCY   = 3;
    localparam int BYPASS_LATENCY = 1;

endpackage

// ==== verilog/mfu_tanh_pkg.sv ====
package mfu_tanh_pkg;

    import mfu_types_pkg::*;

    // Piecewise-linear tanh, y = slope * x + intercept
    localparam int TANH_SEGMENTS = 11;

    typedef logic [3:0] tanh_seg_t;

    // Lower bound of each segment, descending with the index
    // Segment 10 starts at the most negative lane value so it catches everything left
    localparam lane_t TANH_BREAKS [TANH_SEGMENTS] = '{
        8'sd90,
        8'sd39,
        8'sd28,
        8'sd16,
        8'sd1,
        8'sd0,
        -8'sd15,
        -8'sd27,
        -8'sd38,
        -8'sd89,
        -8'sd128
    };

    // Slope per segment, flat at both saturation ends and around zero
    localparam lane_t TANH_SLOPE [TANH_SEGMENTS] = '{
        8'sd0, 8'sd0, 8'sd2, 8'sd3, 8'sd4, 8'sd0,
        8'sd4, 8'sd3, 8'sd2, 8'sd0, 8'sd0
    };

    // Intercept per segment, odd-symmetric around segment 5
    localparam lane_t TANH_INTERCEPT [TANH_SEGMENTS] = '{
        8'sd127,
        8'sd99,
        8'sd46,
        8'sd18,
        8'sd0,
        8'sd0,
        8'sd0,
        -8'sd18,
        -8'sd46,
        -8'sd99,
        -8'sd127
    };

endpackage

// ==== verilog/mfu_operand_if.sv ====
`timescale 1ns/100ps

interface mfu_operand_if;

    import mfu_types_pkg::*;

    // One-hot unit strobes, a single cycle per issued vector
    logic start_add;
    logic start_mul;
    logic start_act;
    logic start_bypass;

    // Payload aligned with the strobes
    act_type_e   act_type;
    mfu_vector_t operand_a;
    mfu_vector_t operand_b;

    modport issue (
        output start_add, start_mul, start_act, start_bypass,
        output act_type, operand_a, operand_b
    );

    modport unit (
        input start_add, start_mul, start_act, start_bypass,
        input act_type, operand_a, operand_b
    );

endinterface

// ==== verilog/vector_register_file.sv ====
`timescale 1ns/100ps

module vector_register_file (
    input  logic                      clk,
    input  logic                      wr_en,
    input  mfu_types_pkg::vrf_addr_t   wr_addr,
    input  mfu_types_pkg::mfu_vector_t wr_data,
    input  mfu_types_pkg::vrf_addr_t   rd_addr,
    output mfu_types_pkg::mfu_vector_t rd_data
);

    import mfu_types_pkg::*;

    // One full vector per entry
    mfu_vector_t mem [VRF_DEPTH];

    // Write port, taken on the enabled edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read
    // Data shows up the cycle after the address, in step with the issue strobe
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/mfu_issue.sv ====
`timescale 1ns/100ps

module mfu_issue (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mfu_types_pkg::mfu_op_e     operation,
    input  mfu_types_pkg::act_type_e   activation_type,
    input  mfu_types_pkg::mfu_vector_t primary_inp,
    input  mfu_types_pkg::mfu_vector_t add_rd_data,
    input  mfu_types_pkg::mfu_vector_t mul_rd_data,
    mfu_operand_if.issue              ops
);

    import mfu_types_pkg::*;

    // Next-cycle strobes
    logic add_d;
    logic mul_d;
    logic act_d;
    logic bypass_d;

    // High when operand_b must come from the multiply bank
    logic mul_bank_q;

    // Opcode decode, nothing fires without in_valid
    always_comb begin
        add_d    = 1'b0;
        mul_d    = 1'b0;
        act_d    = 1'b0;
        bypass_d = 1'b0;
        if (in_valid) begin
            case (operation)
                ACTIVATION: act_d    = 1'b1;
                ELT_ADD:    add_d    = 1'b1;
                ELT_MUL:    mul_d    = 1'b1;
                BYPASS:     bypass_d = 1'b1;
            endcase
        end
    end

    // Strobes, cleared while in reset
    always_ff @(posedge clk) begin
        if (!reset) begin
            ops.start_add    <= 1'b0;
            ops.start_mul    <= 1'b0;
            ops.start_act    <= 1'b0;
            ops.start_bypass <= 1'b0;
        end else begin
            ops.start_add    <= add_d;
            ops.start_mul    <= mul_d;
            ops.start_act    <= act_d;
            ops.start_bypass <= bypass_d;
        end
    end

    // Payload staged with the strobe, same cycle as the RF read data
    always_ff @(posedge clk) begin
        if (in_valid) begin
            ops.operand_a <= primary_inp;
            ops.act_type  <= activation_type;
            mul_bank_q    <= (operation == ELT_MUL);
        end
    end

    // Pick the bank read that matches the staged operation
    assign ops.operand_b = mul_bank_q ? mul_rd_data : add_rd_data;

endmodule

// ==== verilog/elt_wise_unit.sv ====
`timescale 1ns/100ps

module elt_wise_unit (
    input  logic                      clk,
    input  logic                      reset,
    mfu_operand_if.unit               ops,
    output logic                      res_valid,
    output mfu_types_pkg::mfu_vector_t res_data
);

    import mfu_types_pkg::*;

    // Lane results before the output register
    mfu_vector_t sum;
    mfu_vector_t prod;

    // Both results in 8-bit context
    // Sum wraps, product keeps its low byte
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            sum[i]  = ops.operand_a[i] + ops.operand_b[i];
            prod[i] = ops.operand_a[i] * ops.operand_b[i];
        end
    end

    // One result per strobe, one cycle later
    always_ff @(posedge clk) begin
        if (!reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= ops.start_add | ops.start_mul;
        end
    end

    // Result register, holds when idle
    always_ff @(posedge clk) begin
        if (ops.start_add) begin
            res_data <= sum;
        end else if (ops.start_mul) begin
            res_data <= prod;
        end
    end

endmodule

// ==== verilog/tanh_pwl.sv ====
`timescale 1ns/100ps

module tanh_pwl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mfu_types_pkg::mfu_vector_t in_data,
    output logic                      out_valid,
    output mfu_types_pkg::mfu_vector_t out_data
);

    import mfu_types_pkg::*;
    import mfu_tanh_pkg::*;

    // Stage 1 registers
    logic        s1_valid;
    mfu_vector_t slope_term;
    mfu_vector_t intercept_q;

    // Segment per lane, from the input value
    tanh_seg_t seg [NUM_LANES];

    // Smallest index whose lower bound the input reaches
    // Walk from the bottom segment up, last hit wins
    function automatic tanh_seg_t find_segment(lane_t x);
        tanh_seg_t s;
        s = tanh_seg_t'(TANH_SEGMENTS - 1);
        for (int k = TANH_SEGMENTS - 2; k >= 0; k--) begin
            if (x >= TANH_BREAKS[k]) begin
                s = tanh_seg_t'(k);
            end
        end
        return s;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            seg[i] = find_segment(in_data[i]);
        end
    end

    // Valid pipe, two stages deep
    always_ff @(posedge clk) begin
        if (!reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // Stage 1: slope times input, truncated to a lane; intercept staged beside it
    // Stage 2: add them, 8-bit wrap
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            slope_term[i]  <= TANH_SLOPE[seg[i]] * in_data[i];
            intercept_q[i] <= TANH_INTERCEPT[seg[i]];
            out_data[i]    <= slope_term[i] + intercept_q[i];
        end
    end

endmodule

// ==== verilog/activation_unit.sv ====
`timescale 1ns/100ps

module activation_unit (
    input  logic                      clk,
    input  logic                      reset,
    mfu_operand_if.unit               ops,
    output logic                      res_valid,
    output mfu_types_pkg::mfu_vector_t res_data
);

    import mfu_types_pkg::*;

    // ReLU path
    logic        relu_valid;
    mfu_vector_t relu_data;

    // Tanh path
    logic        tanh_start;
    logic        tanh_valid;
    mfu_vector_t tanh_data;

    assign tanh_start = ops.start_act && (ops.act_type == ACT_TANH);

    // ReLU valid, single stage
    always_ff @(posedge clk) begin
        if (!reset) begin
            relu_valid <= 1'b0;
        end else begin
            relu_valid <= ops.start_act && (ops.act_type == ACT_RELU);
        end
    end

    // Sign bit set means negative, clamp the lane to zero
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            relu_data[i] <= ops.operand_a[i][LANE_WIDTH-1] ? '0 : ops.operand_a[i];
        end
    end

    // Tanh takes one cycle more than ReLU
    tanh_pwl u_tanh (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (tanh_start),
        .in_data   (ops.operand_a),
        .out_valid (tanh_valid),
        .out_data  (tanh_data)
    );

    // The stream drains before act_type changes, so at most one path is valid
    assign res_valid = relu_valid | tanh_valid;
    assign res_data  = tanh_valid ? tanh_data : relu_data;

endmodule

// ==== verilog/mfu_top.sv ====
`timescale 1ns/100ps

module mfu_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  mfu_types_pkg::mfu_op_e     operation,
    input  mfu_types_pkg::act_type_e   activation_type,
    input  mfu_types_pkg::mfu_vector_t primary_inp,
    input  mfu_types_pkg::vrf_addr_t   vrf_rd_addr,
    input  logic                      vrf_wr_en,
    input  mfu_types_pkg::vrf_bank_e   vrf_wr_bank,
    input  mfu_types_pkg::vrf_addr_t   vrf_wr_addr,
    input  mfu_types_pkg::mfu_vector_t vrf_wr_data,
    output logic                      out_valid,
    output mfu_types_pkg::mfu_vector_t out_data
);

    import mfu_types_pkg::*;

    logic        add_wr_en;
    logic        mul_wr_en;
    mfu_vector_t add_rd_data;
    mfu_vector_t mul_rd_data;

    logic        elt_valid;
    mfu_vector_t elt_data;
    logic        act_valid;
    mfu_vector_t act_data;

    mfu_operand_if ops_if ();

    // Write steering, both banks share the read address
    assign add_wr_en = vrf_wr_en && (vrf_wr_bank == BANK_ADD);
    assign mul_wr_en = vrf_wr_en && (vrf_wr_bank == BANK_MUL);

    vector_register_file u_add_bank (
        .clk     (clk),
        .wr_en   (add_wr_en),
        .wr_addr (vrf_wr_addr),
        .wr_data (vrf_wr_data),
        .rd_addr (vrf_rd_addr),
        .rd_data (add_rd_data)
    );

    vector_register_file u_mul_bank (
        .clk     (clk),
        .wr_en   (mul_wr_en),
        .wr_addr (vrf_wr_addr),
        .wr_data (vrf_wr_data),
        .rd_addr (vrf_rd_addr),
        .rd_data (mul_rd_data)
    );

    mfu_issue u_issue (
        .clk             (clk),
        .reset           (reset),
        .in_valid        (in_valid),
        .operation       (operation),
        .activation_type (activation_type),
        .primary_inp     (primary_inp),
        .add_rd_data     (add_rd_data),
        .mul_rd_data     (mul_rd_data),
        .ops             (ops_if.issue)
    );

    elt_wise_unit u_elt (
        .clk       (clk),
        .reset     (reset),
        .ops       (ops_if.unit),
        .res_valid (elt_valid),
        .res_data  (elt_data)
    );

    activation_unit u_act (
        .clk       (clk),
        .reset     (reset),
        .ops       (ops_if.unit),
        .res_valid (act_valid),
        .res_data  (act_data)
    );

    // Result select
    // Bypass comes straight from the staged operand, one cycle after issue
    always_comb begin
        out_valid = elt_valid | act_valid | ops_if.start_bypass;
        if (elt_valid) begin
            out_data = elt_data;
        end else if (act_valid) begin
            out_data = act_data;
        end else begin
            out_data = ops_if.operand_a;
        end
    end

endmodule

// ==== verification/mfu_properties.sv ====
`timescale 1ns/100ps

module mfu_properties (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_valid,
    input mfu_types_pkg::mfu_op_e operation,
    input logic                   out_valid,
    input logic                   elt_valid,
    input logic                   act_valid,
    input logic                   bypass_valid
);

    import mfu_types_pkg::*;

    logic elt_issue;
    logic bypass_issue;

    // Assertion failures so far
    int fail_count = 0;

    assign elt_issue    = in_valid && (operation == ELT_ADD || operation == ELT_MUL);
    assign bypass_issue = in_valid && (operation == BYPASS);

    // At most one unit drives the output in a cycle
    one_hot_results: assert property (@(posedge clk) disable iff (!reset)
        $onehot0({elt_valid, act_valid, bypass_valid}))
        else begin
            fail_count++;
            $error("more than one unit result valid in the same cycle");
        end

    // Sync reset, so out_valid is low after every reset edge
    quiet_in_reset: assert property (@(posedge clk) !reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while reset is low");
        end

    bypass_timing: assert property (@(posedge clk) disable iff (!reset)
        $past(bypass_issue, BYPASS_LATENCY) |-> out_valid)
        else begin
            fail_count++;
            $error("bypass result missing one cycle after issue");
        end

    elt_timing: assert property (@(posedge clk) disable iff (!reset)
        $past(elt_issue, ELT_LATENCY) |-> out_valid)
        else begin
            fail_count++;
            $error("element-wise result missing after its latency");
        end

endmodule

bind mfu_top mfu_properties props_i (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .operation    (operation),
    .out_valid    (out_valid),
    .elt_valid    (elt_valid),
    .act_valid    (act_valid),
    .bypass_valid (ops_if.start_bypass)
);

// ==== verification/mfu_tb.sv ====
`timescale 1ns/100ps

module mfu_tb;

    import mfu_types_pkg::*;
    import mfu_tanh_pkg::*;

    // Stimulus row, exp is filled in by the model at issue time
    typedef struct {
        mfu_op_e     op;
        act_type_e   act;
        mfu_vector_t vec;
        vrf_addr_t   addr;
        mfu_vector_t exp;
    } row_t;

    // Result still owed by the DUT, due is the cycle it must show up in
    typedef struct {
        mfu_vector_t exp;
        int          due;
    } pending_t;

    logic        clk;
    logic        reset;
    logic        in_valid;
    mfu_op_e     operation;
    act_type_e   activation_type;
    mfu_vector_t primary_inp;
    vrf_addr_t   vrf_rd_addr;
    logic        vrf_wr_en;
    vrf_bank_e   vrf_wr_bank;
    vrf_addr_t   vrf_wr_addr;
    mfu_vector_t vrf_wr_data;
    logic        out_valid;
    mfu_vector_t out_data;

    row_t        rows [$];
    pending_t    pending [$];
    // Copies of both banks, updated with every write
    mfu_vector_t add_shadow [VRF_DEPTH];
    mfu_vector_t mul_shadow [VRF_DEPTH];
    int          cycle = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          split_row;
    int          watchdog_limit;
    logic        rows_ready = 1'b0;
    logic        result_due;
    logic        have_prev = 1'b0;
    mfu_op_e     prev_op;
    act_type_e   prev_act;

    // Edge cases, two lanes per row
    int relu_inputs [6] = '{-5, 7, 0, -128, 127, -1};
    int tanh_inputs [20] = '{90, 89, 39, 0, -1, -16, -90, -128, 38, 28,
                             16, 15, 1, -27, -28, -38, -39, -89, 127, 30};

    mfu_top dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Counts rising edges
    always @(posedge clk) cycle <= cycle + 1;

    function automatic mfu_vector_t make_vector(int upper, int lower);
        mfu_vector_t v;
        v[1] = lane_t'(upper);
        v[0] = lane_t'(lower);
        return v;
    endfunction

    function automatic mfu_vector_t random_vector();
        logic [31:0] r;
        r = $urandom;
        return r[NUM_LANES*LANE_WIDTH-1:0];
    endfunction

    function automatic void add_row(mfu_op_e op, act_type_e act, mfu_vector_t vec, int addr);
        rows.push_back('{op, act, vec, vrf_addr_t'(addr), '0});
    endfunction

    // Segment from the input ranges, then slope * x truncated plus intercept
    function automatic lane_t tanh_model(lane_t x);
        int    seg;
        lane_t p;
        if (x >= 90) seg = 0;
        else if (x >= 39) seg = 1;
        else if (x >= 28) seg = 2;
        else if (x >= 16) seg = 3;
        else if (x >= 1) seg = 4;
        else if (x == 0) seg = 5;
        else if (x >= -15) seg = 6;
        else if (x >= -27) seg = 7;
        else if (x >= -38) seg = 8;
        else if (x >= -89) seg = 9;
        else seg = 10;
        p = lane_t'(int'(TANH_SLOPE[seg]) * int'(x));
        return lane_t'(int'(p) + int'(TANH_INTERCEPT[seg]));
    endfunction

    // Sums wrap and products keep the low byte
    function automatic mfu_vector_t expected_result(row_t r);
        mfu_vector_t y;
        lane_t       a;
        for (int i = 0; i < NUM_LANES; i++) begin
            a = r.vec[i];
            case (r.op)
                ELT_ADD: y[i] = lane_t'(int'(a) + int'(add_shadow[r.addr][i]));
                ELT_MUL: y[i] = lane_t'(int'(a) * int'(mul_shadow[r.addr][i]));
                ACTIVATION: y[i] = (r.act == ACT_TANH) ? tanh_model(a) : ((a < 0) ? lane_t'(0) : a);
                default: y[i] = a;
            endcase
        end
        return y;
    endfunction

    function automatic int latency_of(row_t r);
        case (r.op)
            ELT_ADD, ELT_MUL: return ELT_LATENCY;
            ACTIVATION: return (r.act == ACT_TANH) ? TANH_LATENCY : RELU_LATENCY;
            default: return BYPASS_LATENCY;
        endcase
    endfunction

    function automatic void build_table();
        // Back-to-back add, then multiply, against the preloaded entries
        for (int a = 0; a < 4; a++) add_row(ELT_ADD, ACT_RELU, random_vector(), a);
        for (int a = 4; a < 8; a++) add_row(ELT_MUL, ACT_RELU, random_vector(), a);
        for (int k = 0; k < 6; k += 2) begin
            add_row(ACTIVATION, ACT_RELU, make_vector(relu_inputs[k], relu_inputs[k+1]), 0);
        end
        add_row(ACTIVATION, ACT_RELU, random_vector(), 0);
        for (int k = 0; k < 20; k += 2) begin
            add_row(ACTIVATION, ACT_TANH, make_vector(tanh_inputs[k], tanh_inputs[k+1]), 0);
        end
        add_row(BYPASS, ACT_RELU, make_vector(-128, 127), 0);
        add_row(BYPASS, ACT_RELU, random_vector(), 0);
        // Random mix
        for (int k = 0; k < 12; k++) begin
            add_row(mfu_op_e'($urandom_range(0, 3)), act_type_e'($urandom_range(0, 1)),
                    random_vector(), $urandom_range(0, VRF_DEPTH - 1));
        end
        // Second read of add entry 2, issued after it is rewritten
        split_row = rows.size();
        add_row(ELT_ADD, ACT_RELU, random_vector(), 2);
    endfunction

    task automatic check_vector(input string name, input mfu_vector_t got, input mfu_vector_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = %h, expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error: %s = %h, expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    // Called on a falling edge, the write lands on the next rising edge
    task automatic write_vrf(input vrf_bank_e bank, input int addr, input mfu_vector_t data);
        vrf_wr_en   = 1'b1;
        vrf_wr_bank = bank;
        vrf_wr_addr = vrf_addr_t'(addr);
        vrf_wr_data = data;
        if (bank == BANK_ADD) add_shadow[addr] = data;
        else mul_shadow[addr] = data;
        @(negedge clk);
        vrf_wr_en = 1'b0;
    endtask

    task automatic drain_results();
        in_valid = 1'b0;
        while (pending.size() != 0) @(negedge clk);
    endtask

    task automatic apply_rows(input int first, input int last);
        for (int i = first; i < last; i++) begin
            // Operation or activation changes only on an empty pipe
            if (have_prev && ((rows[i].op != prev_op) ||
                              (rows[i].op == ACTIVATION && rows[i].act != prev_act))) begin
                drain_results();
            end
            rows[i].exp     = expected_result(rows[i]);
            in_valid        = 1'b1;
            operation       = rows[i].op;
            activation_type = rows[i].act;
            primary_inp     = rows[i].vec;
            vrf_rd_addr     = rows[i].addr;
            pending.push_back('{rows[i].exp, cycle + latency_of(rows[i])});
            have_prev = 1'b1;
            prev_op   = rows[i].op;
            prev_act  = rows[i].act;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // One valid compare per cycle, data compared when a result is due
    always @(negedge clk) begin
        if (cycle > 0) begin
            result_due = (pending.size() != 0) && (pending[0].due == cycle);
            check_valid("out_valid", out_valid, result_due);
            if (result_due) begin
                if (out_valid) check_vector("out_data", out_data, pending[0].exp);
                void'(pending.pop_front());
            end
        end
    end

    // Watchdog sized from the table length
    initial begin
        wait (rows_ready);
        watchdog_limit = 8 + 2 * VRF_DEPTH + 2 * rows.size() * (TANH_LATENCY + 2);
        wait (cycle >= watchdog_limit);
        $display("Timeout: run still going after %0d cycles", watchdog_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(59));
        reset           = 1'b0;
        in_valid        = 1'b0;
        operation       = BYPASS;
        activation_type = ACT_RELU;
        primary_inp     = '0;
        vrf_rd_addr     = '0;
        vrf_wr_en       = 1'b0;
        vrf_wr_bank     = BANK_ADD;
        vrf_wr_addr     = '0;
        vrf_wr_data     = '0;
        build_table();
        rows_ready = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b1;
        // Preload both banks, out_valid must stay low meanwhile
        for (int a = 0; a < VRF_DEPTH; a++) begin
            write_vrf(BANK_ADD, a, random_vector());
            write_vrf(BANK_MUL, a, random_vector());
        end
        apply_rows(0, split_row);
        write_vrf(BANK_ADD, 2, ~add_shadow[2]);
        apply_rows(split_row, rows.size());
        drain_results();
        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut_i.props_i.fail_count);
        if (error_count == 0 && dut_i.props_i.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== mfu_top.f ====
verilog/mfu_types_pkg.sv
verilog/mfu_tanh_pkg.sv
verilog/mfu_operand_if.sv
verilog/vector_register_file.sv
verilog/mfu_issue.sv
verilog/elt_wise_unit.sv
verilog/tanh_pwl.sv
verilog/activation_unit.sv
verilog/mfu_top.sv
verification/mfu_properties.sv
verification/mfu_tb.sv

// ==== run_mfu.sh ====
#!/bin/sh
# Compile with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module mfu_tb -f mfu_top.f -o mfu_sim \
    && ./obj_dir/mfu_sim | tee /dev/stderr | grep -q "^Done: no errors$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
